// ==== build.f ====
hw/rvPkg.sv
hw/ctrlIf.sv
hw/controlDecoder.sv
hw/immGen.sv
hw/alu.sv
hw/pcUnit.sv
hw/riscvTop.sv
testbench/core_asserts.sv
testbench/tbRiscv.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbRiscv -f build.f --Mdir obj_dir \
	&& ./obj_dir/VtbRiscv +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && exit 0 || exit 1

// ==== testbench/tbRiscv.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRiscv;
	import rvPkg::*;

	localparam int ProgLen    = 202; // 200 random words, ADDI x1 and the halt word
	localparam int HoldCycles = 10;
	localparam int CycleLimit = 250; // ProgLen plus hold cycles plus margin

	logic        CLK;
	logic        RSTn;
	logic        iMemCsn;
	logic [11:0] iMemAddr;
	logic [31:0] iMemData;
	logic        dMemCsn;
	logic        dMemWen;
	logic [9:0]  dMemAddr;
	logic [31:0] dMemDout;
	logic [31:0] dMemDi;
	logic        rfWe;
	logic [4:0]  rfRa1;
	logic [4:0]  rfRa2;
	logic [4:0]  rfWa;
	logic [31:0] rfWd;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic        halt;
	logic [31:0] numInst;

	logic [31:0] iMem [1024];
	logic [31:0] dMem [1024];
	logic [31:0] rf   [32];

	// Reference model state
	logic [31:0] mPc;
	logic [31:0] mReg [32];
	logic [31:0] mMem [1024];
	logic        mHalted;
	int          mRetired;

	// Expected effects of the current instruction
	logic        expWe;
	logic [4:0]  expRd;
	logic [31:0] expWd;
	logic        expStore;
	logic [9:0]  expAddr;
	logic [31:0] expData;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          testFails [5];
	int          cycleCount = 0;

	riscvTop #(
		.AddrWidth (12)
	) riscvTop_inst (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.iMemCsn  (iMemCsn),
		.iMemAddr (iMemAddr),
		.iMemData (iMemData),
		.dMemCsn  (dMemCsn),
		.dMemWen  (dMemWen),
		.dMemAddr (dMemAddr),
		.dMemDout (dMemDout),
		.dMemDi   (dMemDi),
		.rfWe     (rfWe),
		.rfRa1    (rfRa1),
		.rfRa2    (rfRa2),
		.rfWa     (rfWa),
		.rfWd     (rfWd),
		.rfRd1    (rfRd1),
		.rfRd2    (rfRd2),
		.halt     (halt),
		.numInst  (numInst)
	);

	// Asynchronous reads with x0 tied to zero
	assign iMemData = iMem[iMemAddr[11:2]];
	assign dMemDi   = dMem[dMemAddr];
	assign rfRd1    = (rfRa1 == 5'd0) ? 32'd0 : rf[rfRa1];
	assign rfRd2    = (rfRa2 == 5'd0) ? 32'd0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa != 5'd0)
			rf[rfWa] <= rfWd;
		if (!dMemCsn && !dMemWen)
			dMem[dMemAddr] <= dMemDout;
	end

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (!RSTn)
			cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: the core did not finish within %0d cycles after reset",
				CycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic        fb;
		int          k;
		val = 32'd0;
		for (k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] genInstr(input int n);
		logic [2:0]  cls;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [19:0] imm20;
		logic [20:0] off;
		logic [6:0]  f7;
		int          maxK;
		logic [31:0] w;
		cls   = 3'(randBits(3));
		f3    = 3'(randBits(3));
		rd    = 5'(randBits(5));
		rs1   = 5'(randBits(5));
		rs2   = 5'(randBits(5));
		imm   = 12'(randBits(12));
		imm20 = 20'(randBits(20));
		maxK  = (ProgLen - 2 - n < 8) ? ProgLen - 2 - n : 8; // never past the ADDI x1
		off   = 21'(4 * (1 + int'(randBits(3)) % maxK));
		case (cls)
			3'd0: w = {imm20, rd, OpLui};
			3'd1: w = {imm20, rd, OpAuipc};
			3'd2: w = {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
			3'd3: begin
				if (f3 == 3'd2 || f3 == 3'd3)
					f3 = f3 + 3'd2; // Map reserved codes to BLT and BGE
				w = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpBranch};
			end
			3'd4: w = {1'b0, imm[8:0], 2'b00, 5'd0, 3'b010, rd, OpLoad};
			3'd5: w = {1'b0, imm[8:3], rs2, 5'd0, 3'b010, imm[2:0], 2'b00, OpStore};
			3'd6: begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					f7 = (f3 == 3'd5 && imm[11]) ? 7'b0100000 : 7'd0;
					w  = {f7, imm[4:0], rs1, f3, rd, OpImm}; // Shift by shamt
				end else begin
					w = {imm, rs1, f3, rd, OpImm};
				end
			end
			default: begin
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[11]) ? 7'b0100000 : 7'd0;
				w  = {f7, rs2, rs1, f3, rd, OpReg};
			end
		endcase
		return w;
	endfunction

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
			input logic [31:0] x, input logic [31:0] y, input logic [4:0] sh);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? x - y : x + y;
			3'd1: r = x << sh;
			3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'd3: r = (x < y) ? 32'd1 : 32'd0;
			3'd4: r = x ^ y;
			3'd5: begin
				if (alt)
					r = $unsigned($signed(x) >>> sh);
				else
					r = x >> sh;
			end
			3'd6: r = x | y;
			default: r = x & y;
		endcase
		return r;
	endfunction

	task automatic executeModel(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] iImm;
		logic [31:0] sImm;
		logic [31:0] bImm;
		logic [31:0] jImm;
		logic [31:0] ea;
		logic [31:0] nextPc;
		logic        taken;
		a        = mReg[w[19:15]];
		b        = mReg[w[24:20]];
		iImm     = {{20{w[31]}}, w[31:20]};
		sImm     = {{20{w[31]}}, w[31:25], w[11:7]};
		bImm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		jImm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		expWe    = 1'b1;
		expRd    = w[11:7];
		expWd    = 32'd0;
		expStore = 1'b0;
		expAddr  = 10'd0;
		expData  = 32'd0;
		taken    = 1'b0;
		nextPc   = mPc + 32'd4;
		case (w[6:0])
			OpLui:   expWd = {w[31:12], 12'd0};
			OpAuipc: expWd = mPc + {w[31:12], 12'd0};
			OpJal: begin
				expWd  = mPc + 32'd4;
				nextPc = mPc + jImm;
			end
			OpJalr: begin
				expWd  = mPc + 32'd4;
				nextPc = (a + iImm) & ~32'd1;
				if (w == 32'h0000_8067 && a == 32'd12) begin // Halt parks the PC
					mHalted = 1'b1;
					nextPc  = mPc;
				end
			end
			OpBranch: begin
				expWe = 1'b0;
				case (w[14:12])
					3'd0:    taken = (a == b);
					3'd1:    taken = (a != b);
					3'd4:    taken = ($signed(a) < $signed(b));
					3'd5:    taken = ($signed(a) >= $signed(b));
					3'd6:    taken = (a < b);
					3'd7:    taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken)
					nextPc = mPc + bImm;
			end
			OpLoad: begin
				ea    = a + iImm;
				expWd = mMem[ea[11:2]];
			end
			OpStore: begin
				expWe         = 1'b0;
				expStore      = 1'b1;
				ea            = a + sImm;
				expAddr       = ea[11:2];
				expData       = b;
				mMem[expAddr] = b;
			end
			OpImm:   expWd = arith(w[14:12], w[30] && w[14:12] == 3'd5, a, iImm, w[24:20]);
			default: expWd = arith(w[14:12], w[30], a, b, b[4:0]);
		endcase
		if (expWe && expRd != 5'd0)
			mReg[expRd] = expWd;
		mPc = nextPc;
		mRetired++;
	endtask

	task automatic checkValue(input int testId, input string name,
			input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			testFails[testId]++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic reportTest(input int testId, input string title);
		if (testFails[testId] == 0)
			$display("test %0d %s: passed", testId + 1, title);
		else
			$display("test %0d %s: failed, %0d mismatches", testId + 1, title, testFails[testId]);
	endtask

	initial begin
		int          i;
		int          failedTests;
		logic [31:0] val;
		lfsr     = 32'he557_8479;
		errors   = 0;
		checks   = 0;
		mHalted  = 1'b0;
		mRetired = 0;
		mPc      = 32'd0;
		RSTn    <= 1'b1;
		for (i = 0; i < 5; i++)
			testFails[i] = 0;
		rf[0]  <= 32'd0;
		mReg[0] = 32'd0;
		for (i = 1; i < 32; i++) begin
			val      = randBits(32);
			rf[i]   <= val;
			mReg[i]  = val;
		end
		for (i = 0; i < 1024; i++) begin
			dMem[i] <= 32'hDA7A_0000 | 32'(i);
			mMem[i]  = 32'hDA7A_0000 | 32'(i);
			iMem[i]  = {2'b00, 10'(i), 5'd0, 3'd0, 5'd0, OpImm}; // ADDI x0 filler
		end
		for (i = 0; i < ProgLen - 2; i++)
			iMem[i] = genInstr(i);
		iMem[ProgLen - 2] = 32'h00C0_0093; // ADDI x1, x0, 12
		iMem[ProgLen - 1] = 32'h0000_8067; // JALR x0, 0(x1)

		@(posedge CLK);
		for (i = 0; i < 3; i++) begin
			@(negedge CLK);
			checkValue(0, "halt", 32'(halt), 32'd0);
			checkValue(0, "numInst", numInst, 32'd0);
			checkValue(0, "rfWe", 32'(rfWe), 32'd0);
			checkValue(0, "dMemWen", 32'(dMemWen), 32'd1);
			checkValue(0, "iMemCsn", 32'(iMemCsn), 32'd1);
			checkValue(0, "dMemCsn", 32'(dMemCsn), 32'd1);
			@(posedge CLK);
		end
		RSTn <= 1'b0;
		@(negedge CLK);
		checkValue(0, "iMemAddr", 32'(iMemAddr), 32'd0);
		reportTest(0, "reset state");

		while (!mHalted) begin
			checkValue(1, "iMemAddr", 32'(iMemAddr), mPc);
			checkValue(1, "iMemCsn", 32'(iMemCsn), 32'd0);
			executeModel(iMem[mPc[11:2]]);
			checkValue(2, "rfWe", 32'(rfWe), 32'(expWe));
			if (expWe) begin
				checkValue(2, "rfWa", 32'(rfWa), 32'(expRd));
				checkValue(2, "rfWd", rfWd, expWd);
			end
			checkValue(3, "dMemWen", 32'(dMemWen), 32'(!expStore));
			if (expStore) begin
				checkValue(3, "dMemCsn", 32'(dMemCsn), 32'd0);
				checkValue(3, "dMemAddr", 32'(dMemAddr), 32'(expAddr));
				checkValue(3, "dMemDout", dMemDout, expData);
			end
			@(negedge CLK);
		end
		reportTest(1, "program order");
		reportTest(2, "register writes");
		reportTest(3, "stores");

		// Frozen from the first cycle after halt on
		for (i = 0; i <= HoldCycles; i++) begin
			checkValue(4, "halt", 32'(halt), 32'd1);
			checkValue(4, "numInst", numInst, 32'(mRetired));
			checkValue(4, "iMemAddr", 32'(iMemAddr), mPc);
			checkValue(4, "rfWe", 32'(rfWe), 32'd0);
			checkValue(4, "dMemWen", 32'(dMemWen), 32'd1);
			checkValue(4, "iMemCsn", 32'(iMemCsn), 32'd1);
			checkValue(4, "dMemCsn", 32'(dMemCsn), 32'd1);
			@(negedge CLK);
		end
		reportTest(4, "halt and count");

		failedTests = 0;
		for (i = 0; i < 5; i++)
			if (testFails[i] != 0)
				failedTests++;
		$display("tests 5, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
			failedTests, checks, errors, riscvTop_inst.coreAsserts_inst.failCount);
		if (errors == 0 && riscvTop_inst.coreAsserts_inst.failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreAsserts #(
	parameter int AddrWidth = 12
) (
	input logic                 CLK,
	input logic                 RSTn,
	input logic                 halt,
	input logic                 rfWe,
	input logic                 dMemWen,
	input logic [AddrWidth-1:0] iMemAddr
);

	int failCount = 0;

	// No register or memory write once halted
	haltQuiet: assert property (@(posedge CLK) disable iff (RSTn) halt |-> (!rfWe && dMemWen))
		else begin
			failCount++;
			$error("register or memory write while halted");
		end

	haltSticky: assert property (@(posedge CLK) disable iff (RSTn) halt |=> halt)
		else begin
			failCount++;
			$error("halt fell without reset");
		end

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) iMemAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("instruction address not word aligned");
		end

endmodule

bind riscvTop coreAsserts #(
	.AddrWidth (AddrWidth)
) coreAsserts_inst (
	.CLK      (CLK),
	.RSTn     (RSTn),
	.halt     (halt),
	.rfWe     (rfWe),
	.dMemWen  (dMemWen),
	.iMemAddr (iMemAddr)
);

`default_nettype wire

// ==== hw/riscvTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTop #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,

	// Instruction memory
	output logic                 iMemCsn,
	output logic [AddrWidth-1:0] iMemAddr, // byte address
	input  logic [31:0]          iMemData,

	// Data memory
	output logic                 dMemCsn,
	output logic                 dMemWen,  // active low
	output logic [9:0]           dMemAddr, // word address
	output logic [31:0]          dMemDout,
	input  logic [31:0]          dMemDi,

	// Register file
	output logic                 rfWe,
	output logic [4:0]           rfRa1,
	output logic [4:0]           rfRa2,
	output logic [4:0]           rfWa,
	output logic [31:0]          rfWd,
	input  logic [31:0]          rfRd1,
	input  logic [31:0]          rfRd2,

	output logic                 halt,
	output logic [31:0]          numInst
);
	import rvPkg::*;

	instrT                instr;
	logic [31:0]          imm;
	logic [31:0]          aluA;
	logic [31:0]          aluB;
	logic [31:0]          aluResult;
	logic [AddrWidth-1:0] pc;
	logic [AddrWidth-1:0] pcPlus4;
	logic                 haltReq;
	logic                 active; // out of reset and not halted
	logic                 memRead;

	ctrlIf ctrl ();

	assign instr = iMemData;

	controlDecoder controlDecoder_inst (
		.instr (instr),
		.ctrl  (ctrl.decoder)
	);

	immGen immGen_inst (
		.instr (instr),
		.imm   (imm)
	);

	assign aluA = ctrl.aluSrcPc  ? {{(32-AddrWidth){1'b0}}, pc} : rfRd1;
	assign aluB = ctrl.aluSrcImm ? imm : rfRd2;

	alu alu_inst (
		.a      (aluA),
		.b      (aluB),
		.op     (ctrl.aluOp),
		.result (aluResult)
	);

	assign haltReq = (iMemData == HaltInstr) && (rfRd1 == HaltLinkValue);

	pcUnit #(
		.AddrWidth (AddrWidth)
	) pcUnit_inst (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.ctrl      (ctrl.datapath),
		.imm       (imm),
		.aluResult (aluResult),
		.haltReq   (haltReq),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.halt      (halt),
		.numInst   (numInst)
	);

	assign active  = ~RSTn & ~halt;
	assign memRead = (ctrl.wbSel == WbMem);

	assign iMemCsn  = ~active;
	assign iMemAddr = pc;

	assign rfRa1 = instr.r.rs1;
	assign rfRa2 = instr.r.rs2;
	assign rfWa  = instr.r.rd;
	assign rfWe  = active & ctrl.regWrite;

	always_comb begin
		case (ctrl.wbSel)
			WbMem:   rfWd = dMemDi;
			WbPc4:   rfWd = {{(32-AddrWidth){1'b0}}, pcPlus4}; // link value
			WbUimm:  rfWd = imm;
			default: rfWd = aluResult;
		endcase
	end

	assign dMemCsn  = ~(active & (ctrl.memWrite | memRead));
	assign dMemWen  = ~(active & ctrl.memWrite);
	assign dMemAddr = aluResult[11:2];
	assign dMemDout = rfRd2;

endmodule

`default_nettype wire

// ==== hw/pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	ctrlIf.datapath              ctrl,
	input  logic [31:0]          imm,
	input  logic [31:0]          aluResult,
	input  logic                 haltReq,
	output logic [AddrWidth-1:0] pc,
	output logic [AddrWidth-1:0] pcPlus4,
	output logic                 halt,
	output logic [31:0]          numInst
);

	logic                 takeBranch;
	logic [AddrWidth-1:0] pcTarget;
	logic [AddrWidth-1:0] nextPc;

	assign pcPlus4    = pc + AddrWidth'(4);
	assign pcTarget   = pc + imm[AddrWidth-1:0];
	assign takeBranch = ctrl.isBranch & aluResult[0];

	always_comb begin
		if (ctrl.isJalr)
			nextPc = {aluResult[AddrWidth-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
		else if (ctrl.isJal || takeBranch)
			nextPc = pcTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= '0;
			halt    <= 1'b0;
			numInst <= 32'b0;
		end else if (!halt) begin
			numInst <= numInst + 32'd1; // halt instruction counts too
			halt    <= haltReq;
			// Stay parked on the halt instruction
			if (!haltReq)
				pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  rvPkg::aluOpT op,
	output logic [31:0] result
);
	import rvPkg::*;

	logic [4:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;

	assign shamt        = b[4:0];
	assign lessSigned   = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			AluAdd:  result = a + b;
			AluSub:  result = a - b;
			AluSll:  result = a << shamt;
			AluSlt:  result = {31'b0, lessSigned};   // also BLT
			AluSltu: result = {31'b0, lessUnsigned}; // also BLTU
			AluXor:  result = a ^ b;
			AluSrl:  result = a >> shamt;
			AluSra:  result = $unsigned($signed(a) >>> shamt);
			AluOr:   result = a | b;
			AluAnd:  result = a & b;

			// Branch tests, truth value in bit 0
			AluEq:   result = {31'b0, a == b};
			AluNe:   result = {31'b0, a != b};
			AluGe:   result = {31'b0, ~lessSigned};
			AluGeu:  result = {31'b0, ~lessUnsigned};
			default: result = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen (
	input  rvPkg::instrT instr,
	output logic [31:0]  imm
);
	import rvPkg::*;

	logic isShiftImm;

	assign isShiftImm = (instr.i.funct3 == F3Sll) || (instr.i.funct3 == F3Srl);

	always_comb begin
		case (instr.r.opcode)
			OpImm: begin
				if (isShiftImm)
					imm = {27'b0, instr.r.rs2}; // shamt, zero extended
				else
					imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			OpJalr, OpLoad: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			OpStore: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
			OpBranch: begin
				imm = {{19{instr.b.immSign}}, instr.b.immSign, instr.b.immB11,
				       instr.b.immHi, instr.b.immLo, 1'b0};
			end
			OpLui, OpAuipc: imm = {instr.u.imm, 12'b0};
			OpJal: begin
				imm = {{11{instr.j.immSign}}, instr.j.immSign, instr.j.immHi,
				       instr.j.immB11, instr.j.immLo, 1'b0};
			end
			default: imm = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input  rvPkg::instrT instr,
	ctrlIf.decoder       ctrl
);
	import rvPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       altBit; // funct7[5], selects SUB and SRA

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign altBit = instr.r.funct7[5];

	// Shared by OP and OP-IMM
	function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
		aluOpT op;
		case (f3)
			F3Add:   op = alt ? AluSub : AluAdd;
			F3Sll:   op = AluSll;
			F3Slt:   op = AluSlt;
			F3Sltu:  op = AluSltu;
			F3Xor:   op = AluXor;
			F3Srl:   op = alt ? AluSra : AluSrl;
			F3Or:    op = AluOr;
			default: op = AluAnd;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl.aluOp     = AluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.aluSrcPc  = 1'b0;
		ctrl.regWrite  = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.wbSel     = WbAlu;
		ctrl.isBranch  = 1'b0;
		ctrl.isJal     = 1'b0;
		ctrl.isJalr    = 1'b0;

		case (opcode)
			OpLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = WbUimm;
			end
			OpAuipc: begin
				ctrl.aluSrcPc  = 1'b1; // PC + upper imm
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			OpJal: begin
				ctrl.isJal    = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = WbPc4;
			end
			OpJalr: begin
				ctrl.isJalr    = 1'b1;
				ctrl.aluSrcImm = 1'b1; // target is rs1 + imm
				ctrl.regWrite  = 1'b1;
				ctrl.wbSel     = WbPc4;
			end
			OpBranch: begin
				ctrl.isBranch = 1'b1;
				case (funct3)
					F3Beq:   ctrl.aluOp = AluEq;
					F3Bne:   ctrl.aluOp = AluNe;
					F3Blt:   ctrl.aluOp = AluSlt;
					F3Bge:   ctrl.aluOp = AluGe;
					F3Bltu:  ctrl.aluOp = AluSltu;
					F3Bgeu:  ctrl.aluOp = AluGeu;
					default: ctrl.isBranch = 1'b0; // reserved funct3 never taken
				endcase
			end
			OpLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				ctrl.wbSel     = WbMem;
			end
			OpStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
			end
			OpImm: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				// No SUBI, the alt bit only matters for SRAI
				ctrl.aluOp     = arithOp(funct3, altBit && (funct3 == F3Srl));
			end
			OpReg: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = arithOp(funct3, altBit);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
	import rvPkg::*;

	aluOpT aluOp;
	logic  aluSrcImm; // B operand is imm
	logic  aluSrcPc;  // A operand is PC, AUIPC only
	logic  regWrite;
	logic  memWrite;
	wbSelT wbSel;
	logic  isBranch;
	logic  isJal;
	logic  isJalr;

	modport decoder (
		output aluOp, aluSrcImm, aluSrcPc, regWrite, memWrite,
		output wbSel, isBranch, isJal, isJalr
	);

	// Next-PC selection only
	modport datapath (
		input isBranch, isJal, isJalr
	);

endinterface

`default_nettype wire

// ==== hw/rvPkg.sv ====
`default_nettype none

package rvPkg;

	// Major opcodes
	localparam logic [6:0] OpLui    = 7'b0110111;
	localparam logic [6:0] OpAuipc  = 7'b0010111;
	localparam logic [6:0] OpJal    = 7'b1101111;
	localparam logic [6:0] OpJalr   = 7'b1100111;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpImm    = 7'b0010011;
	localparam logic [6:0] OpReg    = 7'b0110011;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3Add  = 3'b000;
	localparam logic [2:0] F3Sll  = 3'b001;
	localparam logic [2:0] F3Slt  = 3'b010;
	localparam logic [2:0] F3Sltu = 3'b011;
	localparam logic [2:0] F3Xor  = 3'b100;
	localparam logic [2:0] F3Srl  = 3'b101;
	localparam logic [2:0] F3Or   = 3'b110;
	localparam logic [2:0] F3And  = 3'b111;

	// funct3 for conditional branches
	localparam logic [2:0] F3Beq  = 3'b000;
	localparam logic [2:0] F3Bne  = 3'b001;
	localparam logic [2:0] F3Blt  = 3'b100;
	localparam logic [2:0] F3Bge  = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	localparam logic [31:0] HaltLinkValue = 32'd12; // x1 value marking halt
	localparam logic [31:0] HaltInstr     = 32'h0000_8067; // JALR x0, 0(x1)

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor, AluSrl,
		AluSra, AluOr, AluAnd, AluEq, AluNe, AluGe, AluGeu
	} aluOpT;

	typedef enum logic [1:0] {WbAlu, WbMem, WbPc4, WbUimm} wbSelT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sTypeT;

	typedef struct packed {
		logic       immSign; // imm[12]
		logic [5:0] immHi;   // imm[10:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;   // imm[4:1]
		logic       immB11;
		logic [6:0] opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm; // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uTypeT;

	typedef struct packed {
		logic       immSign; // imm[20]
		logic [9:0] immLo;   // imm[10:1]
		logic       immB11;
		logic [7:0] immHi;   // imm[19:12]
		logic [4:0] rd;
		logic [6:0] opcode;
	} jTypeT;

	typedef union packed {
		rTypeT r;
		iTypeT i;
		sTypeT s;
		bTypeT b;
		uTypeT u;
		jTypeT j;
	} instrT;

endpackage

`default_nettype wire
